//--- rtl/codec_ctrl_top.sv
module codec_ctrl_top
    import codec_phase_pkg::*;
    import op_status_pkg::*;
#(
    parameter int MAX_MERGE_PASSES = 8
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       restart,
    input  logic       cmd_valid,
    output logic       cmd_ready,
    input  logic       cmd_comp,   // 1 selects compress
    output logic       eng_start,
    output op_status_t eng_phase,
    input  logic       eng_done,
    input  logic       eng_more,
    input  logic       eng_err,
    output op_status_t op_status,
    output logic       finished
);

    phase_if #(.PHASE_W(COMP_PHASE_W))   comp_link ();
    phase_if #(.PHASE_W(DECOMP_PHASE_W)) decomp_link ();

    op_status_tracker i_tracker (
        .clk         (clk),
        .rst         (rst),
        .restart     (restart),
        .cmd_valid   (cmd_valid),
        .cmd_ready   (cmd_ready),
        .cmd_comp    (cmd_comp),
        .eng_start   (eng_start),
        .eng_phase   (eng_phase),
        .eng_done    (eng_done),
        .eng_more    (eng_more),
        .eng_err     (eng_err),
        .op_status   (op_status),
        .finished    (finished),
        .comp_link   (comp_link.tracker),
        .decomp_link (decomp_link.tracker)
    );

    comp_sequencer #(
        .MAX_MERGE_PASSES (MAX_MERGE_PASSES)
    ) i_comp_seq (
        .clk     (clk),
        .rst     (rst),
        .restart (restart),
        .link    (comp_link.sequencer)
    );

    decomp_sequencer i_decomp_seq (
        .clk     (clk),
        .rst     (rst),
        .restart (restart),
        .link    (decomp_link.sequencer)
    );

endmodule

//--- rtl/codec_phase_pkg.sv
package codec_phase_pkg;

    // ========================================
    // Compress phase codes
    // ========================================
    localparam int COMP_PHASE_W = 4;

    typedef enum logic [COMP_PHASE_W-1:0] {
        C_IDLE  = 4'd0,
        C_HISTO = 4'd1,  // Histogram
        C_FLV   = 4'd2,  // Frequency list
        C_HTREE = 4'd3,  // Tree build
        C_CBS   = 4'd4,  // Codebook
        C_TRN   = 4'd5,  // Translate
        C_SPI   = 4'd6,  // SPI output
        C_ERR   = 4'd7,
        C_DONE  = 4'd8
    } comp_phase_t;

    // ========================================
    // Decompress state index and pass count
    // ========================================
    localparam int DECOMP_PHASE_W = 2;
    localparam int PASS_CNT_W     = 8;

    typedef logic [DECOMP_PHASE_W-1:0] decomp_phase_t;  // Decode state 0 to 3
    typedef logic [PASS_CNT_W-1:0]     pass_cnt_t;      // Merge passes so far

endpackage

//--- rtl/comp_sequencer.sv
module comp_sequencer
    import codec_phase_pkg::*;
#(
    parameter int MAX_MERGE_PASSES = 8
) (
    input  logic clk,
    input  logic rst,
    input  logic restart,
    phase_if.sequencer link
);

    comp_phase_t state;
    comp_phase_t next_state;
    pass_cnt_t   pass_cnt;
    logic        tree_more;
    logic        overrun;

    // Another pass requested after the last allowed one
    assign tree_more = (state == C_HTREE) && link.done && !link.err && link.more;
    assign overrun   = tree_more && (pass_cnt >= pass_cnt_t'(MAX_MERGE_PASSES));

    // ========================================
    // Phase state machine
    // ========================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= C_IDLE;
            pass_cnt <= '0;
        end else if (restart) begin
            state    <= C_IDLE;
            pass_cnt <= '0;
        end else begin
            state <= next_state;
            if (state == C_IDLE && link.go) begin
                pass_cnt <= pass_cnt_t'(1);  // First FLV/HTREE pass
            end else if (tree_more && !overrun) begin
                pass_cnt <= pass_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            C_IDLE:  if (link.go) next_state = C_HISTO;
            C_HISTO: if (link.err) next_state = C_ERR;
                     else if (link.done) next_state = C_FLV;
            C_FLV:   if (link.err) next_state = C_ERR;
                     else if (link.done) next_state = C_HTREE;
            C_HTREE: begin
                if (link.err || overrun) begin
                    next_state = C_ERR;
                end else if (tree_more) begin
                    next_state = C_FLV;  // Merge loop
                end else if (link.done) begin
                    next_state = C_CBS;
                end
            end
            C_CBS:   if (link.err) next_state = C_ERR;
                     else if (link.done) next_state = C_TRN;
            C_TRN:   if (link.err) next_state = C_ERR;
                     else if (link.done) next_state = C_SPI;
            C_SPI:   if (link.err) next_state = C_ERR;
                     else if (link.done) next_state = C_DONE;
            C_DONE:  next_state = C_IDLE;
            C_ERR:   next_state = C_ERR;  // Held until restart
            default: next_state = C_IDLE;
        endcase
    end

    // ========================================
    // Link outputs
    // ========================================
    assign link.req   = (state >= C_HISTO) && (state <= C_SPI);
    assign link.phase = state;
    assign link.fin   = (state == C_SPI) && link.done && !link.err;
    assign link.fault = overrun;

endmodule

//--- rtl/decomp_sequencer.sv
module decomp_sequencer
    import codec_phase_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic restart,
    phase_if.sequencer link
);

    typedef enum logic [1:0] {
        D_IDLE,
        D_RUN,
        D_ERR
    } dec_state_t;

    dec_state_t    state;
    decomp_phase_t idx;
    logic          last;

    assign last = (idx == decomp_phase_t'(3));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= D_IDLE;
            idx   <= '0;
        end else if (restart) begin
            state <= D_IDLE;
            idx   <= '0;
        end else begin
            case (state)
                D_IDLE: begin
                    if (link.go) begin
                        state <= D_RUN;
                        idx   <= '0;  // Start at decode state 0
                    end
                end
                D_RUN: begin
                    if (link.err) begin
                        state <= D_ERR;
                    end else if (link.done) begin
                        if (last) state <= D_IDLE;
                        idx <= idx + 1'b1;
                    end
                end
                D_ERR:   state <= D_ERR;  // Wait for restart
                default: state <= D_IDLE;
            endcase
        end
    end

    assign link.req   = (state == D_RUN);
    assign link.phase = idx;
    assign link.fin   = (state == D_RUN) && link.done && !link.err && last;
    assign link.fault = 1'b0;  // No pass guard in decode

endmodule

//--- rtl/op_status_pkg.sv
package op_status_pkg;

    localparam int OP_STATUS_W = 4;

    // Status codes seen by the host and the engine
    typedef enum logic [OP_STATUS_W-1:0] {
        IDLE   = 4'd0,
        SELECT = 4'd1,
        COMP   = 4'd2,
        HISTO  = 4'd3,
        FLV    = 4'd4,
        HTREE  = 4'd5,
        CBS    = 4'd6,
        TRN    = 4'd7,
        SPI    = 4'd8,
        DECOMP = 4'd9,
        STATE0 = 4'd10,
        STATE1 = 4'd11,
        STATE2 = 4'd12,
        STATE3 = 4'd13,
        DONE   = 4'd14,
        ERROR  = 4'd15  // Sticky until restart
    } op_status_t;

endpackage

//--- rtl/op_status_tracker.sv
module op_status_tracker
    import codec_phase_pkg::*;
    import op_status_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       restart,
    input  logic       cmd_valid,
    output logic       cmd_ready,
    input  logic       cmd_comp,
    output logic       eng_start,
    output op_status_t eng_phase,
    input  logic       eng_done,
    input  logic       eng_more,
    input  logic       eng_err,
    output op_status_t op_status,
    output logic       finished,
    phase_if.tracker   comp_link,
    phase_if.tracker   decomp_link
);

    op_status_t st;
    op_status_t next_st;
    op_status_t phase_status;
    logic       comp_mode;
    logic       go_q;
    logic       comp_act;
    logic       decomp_act;
    logic       act_req;
    logic       act_fin;
    logic       act_fault;
    logic       eng_fail;

    assign comp_act   = (st == COMP);
    assign decomp_act = (st == DECOMP);
    assign act_req    = (comp_act && comp_link.req) || (decomp_act && decomp_link.req);
    assign act_fin    = (comp_act && comp_link.fin) || (decomp_act && decomp_link.fin);
    assign act_fault  = comp_act && comp_link.fault;
    assign eng_fail   = (comp_act || decomp_act) && eng_done && eng_err;

    // ========================================
    // Command and status state machine
    // ========================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st        <= IDLE;
            comp_mode <= 1'b0;
            go_q      <= 1'b0;
        end else if (restart) begin
            st        <= IDLE;
            comp_mode <= 1'b0;
            go_q      <= 1'b0;
        end else begin
            st   <= next_st;
            go_q <= (st == SELECT);  // One cycle in COMP or DECOMP
            if (cmd_valid && cmd_ready) comp_mode <= cmd_comp;
        end
    end

    always_comb begin
        next_st = st;
        case (st)
            IDLE:        if (cmd_valid) next_st = SELECT;
            SELECT:      next_st = comp_mode ? COMP : DECOMP;
            COMP, DECOMP: begin
                if (act_fault || eng_fail) next_st = ERROR;
                else if (act_fin) next_st = DONE;
            end
            DONE:        next_st = IDLE;
            ERROR:       next_st = ERROR;
            default:     next_st = IDLE;
        endcase
    end

    // Active sequencer phase as a status code
    always_comb begin
        phase_status = st;
        if (comp_act && comp_link.req) begin
            case (comp_phase_t'(comp_link.phase))
                C_HISTO: phase_status = HISTO;
                C_FLV:   phase_status = FLV;
                C_HTREE: phase_status = HTREE;
                C_CBS:   phase_status = CBS;
                C_TRN:   phase_status = TRN;
                C_SPI:   phase_status = SPI;
                default: phase_status = st;
            endcase
        end else if (decomp_act && decomp_link.req) begin
            case (decomp_phase_t'(decomp_link.phase))
                2'd0:    phase_status = STATE0;
                2'd1:    phase_status = STATE1;
                2'd2:    phase_status = STATE2;
                default: phase_status = STATE3;
            endcase
        end
    end

    // ========================================
    // Link relay and outputs
    // ========================================
    assign comp_link.go     = go_q && comp_act;
    assign comp_link.done   = comp_act && eng_done;
    assign comp_link.more   = comp_act && eng_more;
    assign comp_link.err    = comp_act && eng_done && eng_err;
    assign decomp_link.go   = go_q && decomp_act;
    assign decomp_link.done = decomp_act && eng_done;
    assign decomp_link.more = decomp_act && eng_more;
    assign decomp_link.err  = decomp_act && eng_done && eng_err;

    assign cmd_ready = (st == IDLE);
    assign eng_start = act_req;
    assign op_status = phase_status;
    assign eng_phase = phase_status;
    assign finished  = (st == DONE);

endmodule

//--- rtl/phase_if.sv
interface phase_if #(
    parameter int PHASE_W = 4
);
    logic               go;     // Start pulse from tracker
    logic               done;   // Engine done, active link only
    logic               more;   // More merges remain
    logic               err;    // Engine error, qualified by done
    logic               req;    // Engine request from sequencer
    logic [PHASE_W-1:0] phase;
    logic               fin;    // Operation complete
    logic               fault;  // Merge pass overrun

    modport tracker (
        output go, done, more, err,
        input  req, phase, fin, fault
    );

    modport sequencer (
        input  go, done, more, err,
        output req, phase, fin, fault
    );

endinterface

//--- tb.f
rtl/codec_phase_pkg.sv
rtl/op_status_pkg.sv
rtl/phase_if.sv
rtl/comp_sequencer.sv
rtl/decomp_sequencer.sv
rtl/op_status_tracker.sv
rtl/codec_ctrl_top.sv
verif/codec_ctrl_properties.sv
verif/codec_ctrl_tb.sv

//--- verif/codec_ctrl_properties.sv
module codec_ctrl_properties
    import op_status_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input logic       restart,
    input logic       eng_start,
    input logic       eng_done,
    input op_status_t eng_phase,
    input logic       finished,
    input logic       cmd_ready,
    input op_status_t op_status
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;  // Read by the testbench at the end

    // ========================================
    // Engine and host port rules
    // ========================================
    phase_stable: assert property (@(posedge clk) disable iff (rst || restart)
        (eng_start && !eng_done) |=> $stable(eng_phase))
        else begin
            fail_count++;
            $error("eng_phase changed before eng_done");
        end

    finished_single: assert property (@(posedge clk) disable iff (rst)
        finished |=> !finished)
        else begin
            fail_count++;
            $error("finished held for more than one cycle");
        end

    ready_idle_only: assert property (@(posedge clk) disable iff (rst)
        (op_status != IDLE) |-> !cmd_ready)
        else begin
            fail_count++;
            $error("cmd_ready high outside IDLE");
        end

endmodule

bind codec_ctrl_top codec_ctrl_properties i_props (.*);

//--- verif/codec_ctrl_tb.sv
module codec_ctrl_tb
    import op_status_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_PASSES = 8;   // Top level default
    localparam int WAIT_LIMIT = 20;  // Cycles per wait loop

    logic       clk;
    logic       rst;
    logic       restart;
    logic       cmd_valid;
    logic       cmd_ready;
    logic       cmd_comp;
    logic       eng_start;
    op_status_t eng_phase;
    logic       eng_done;
    logic       eng_more;
    logic       eng_err;
    op_status_t op_status;
    logic       finished;
    int         seed;

    codec_ctrl_top i_dut (.*);

    always #2 clk = ~clk;

    // ========================================
    // Helpers
    // ========================================
    task automatic abort_run();
        $display("Some tests failed");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("FAIL %s expected %0d actual %0d", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out waiting for %s", what);
        abort_run();
    endtask

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // Host keeps offering commands while busy
    task automatic offer_busy_command();
        check_value("cmd_ready busy", 0, cmd_ready);
        cmd_valid = (rand_below(2) == 1);
        cmd_comp  = (rand_below(2) == 1);
    endtask

    task automatic apply_restart();
        cmd_valid = 1'b0;
        restart   = 1'b1;
        @(negedge clk);
        restart   = 1'b0;
        check_value("status after restart", IDLE, op_status);
        check_value("cmd_ready after restart", 1, cmd_ready);
        check_value("eng_start after restart", 0, eng_start);
    endtask

    task automatic wait_cmd_ready();
        int waited;
        waited = 0;
        while (!cmd_ready) begin
            waited++;
            if (waited > WAIT_LIMIT) report_timeout("cmd_ready");
            @(negedge clk);
        end
    endtask

    // One command with the engine responder
    // err_at and stop_at hold a phase index or -1 when unused
    task automatic run_operation(input logic comp, input int passes, input int err_at,
                                 input int stop_at);
        op_status_t exp_q[$];
        int         fail_at;
        int         waited;
        int         idx;
        int         p;

        if (comp) begin
            exp_q.push_back(HISTO);
            for (p = 0; p < passes; p++) begin
                exp_q.push_back(FLV);
                exp_q.push_back(HTREE);
            end
            exp_q.push_back(CBS);
            exp_q.push_back(TRN);
            exp_q.push_back(SPI);
        end else begin
            exp_q = '{STATE0, STATE1, STATE2, STATE3};
        end
        fail_at = err_at;
        if (comp && passes > MAX_PASSES) fail_at = 2 * MAX_PASSES;  // Last allowed HTREE

        wait_cmd_ready();
        cmd_valid = 1'b1;
        cmd_comp  = comp;
        @(negedge clk);
        check_value("status select", SELECT, op_status);
        offer_busy_command();
        @(negedge clk);
        check_value("status mode", comp ? COMP : DECOMP, op_status);
        check_value("eng_start at go", 0, eng_start);
        for (idx = 0; idx < exp_q.size(); idx++) begin
            waited = 0;
            while (!eng_start) begin
                offer_busy_command();
                waited++;
                if (waited > WAIT_LIMIT) report_timeout("eng_start");
                @(negedge clk);
            end
            check_value("phase order", exp_q[idx], eng_phase);
            check_value("status phase", exp_q[idx], op_status);
            if (idx == stop_at) begin
                apply_restart();
                return;
            end
            repeat (rand_below(6)) begin  // Engine back-pressure
                offer_busy_command();
                @(negedge clk);
                check_value("eng_start held", 1, eng_start);
                check_value("phase held", exp_q[idx], eng_phase);
            end
            eng_done = 1'b1;
            eng_more = comp && (exp_q[idx] == HTREE) && (idx / 2 < passes);
            eng_err  = (idx == err_at);
            @(negedge clk);
            eng_done = 1'b0;
            eng_more = 1'b0;
            eng_err  = 1'b0;
            if (idx == fail_at) begin
                cmd_valid = 1'b0;
                repeat (3) begin
                    check_value("status error", ERROR, op_status);
                    check_value("eng_start in error", 0, eng_start);
                    check_value("finished in error", 0, finished);
                    @(negedge clk);
                end
                return;
            end
        end
        cmd_valid = 1'b0;
        check_value("status done", DONE, op_status);
        check_value("finished pulse", 1, finished);
        @(negedge clk);
        check_value("status idle", IDLE, op_status);
        check_value("finished low", 0, finished);
        check_value("cmd_ready idle", 1, cmd_ready);
    endtask

    // ========================================
    // Test sequence
    // ========================================
    initial begin
        int n;
        seed      = 32'h4f58;
        clk       = 1'b0;
        rst       = 1'b1;
        restart   = 1'b0;
        cmd_valid = 1'b0;
        cmd_comp  = 1'b0;
        eng_done  = 1'b0;
        eng_more  = 1'b0;
        eng_err   = 1'b0;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        check_value("status after reset", IDLE, op_status);
        check_value("cmd_ready after reset", 1, cmd_ready);
        check_value("eng_start after reset", 0, eng_start);
        check_value("finished after reset", 0, finished);

        for (n = 0; n < 8; n++) run_operation(1'b1, 1 + rand_below(MAX_PASSES), -1, -1);
        run_operation(1'b1, MAX_PASSES, -1, -1);
        for (n = 0; n < 4; n++) run_operation(1'b0, 0, -1, -1);
        for (n = 0; n < 6; n++) run_operation(n[0], 1 + rand_below(3), -1, -1);

        run_operation(1'b1, MAX_PASSES + 1 + rand_below(2), -1, -1);  // Pass overrun
        apply_restart();
        for (n = 0; n < 4; n++) begin
            run_operation(1'b1, 3, rand_below(10), -1);
            apply_restart();
            run_operation(1'b0, 0, rand_below(4), -1);
            apply_restart();
        end

        for (n = 0; n < 4; n++) begin  // Restart mid operation
            run_operation(1'b1, 4, -1, rand_below(12));
            run_operation(1'b1, 2, -1, -1);
            run_operation(1'b0, 0, -1, rand_below(4));
            run_operation(1'b0, 0, -1, -1);
        end

        if (i_dut.i_props.fail_count == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            $display("Bound property checks failed %0d times", i_dut.i_props.fail_count);
            abort_run();
        end
    end

endmodule
